// File: Makefile
# Verilator build and run of the pulse registration testbench
# The binary exits with a failing status on any $fatal in the testbench

SRCS := $(shell cat src.f)

obj_dir/Vtb_pulse_reg: $(SRCS) src.f
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_pulse_reg -f src.f

run: obj_dir/Vtb_pulse_reg
	./obj_dir/Vtb_pulse_reg

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: design/byte_tally.sv
//********************
// Uplink byte counter, saturates at all ones
// Count is latched and restarted one cycle after a request
//********************
`timescale 1ns/1ps

module byte_tally (
	input  logic                            fifo_clk,
	input  logic                            rst,
	input  logic                            count_en,
	input  logic                            request_length,
	output logic [pulse_reg_pkg::LEN_W-1:0] length
);
	import pulse_reg_pkg::*;

	logic [LEN_W-1:0] count;	// Bytes since last request

	always_ff @(posedge fifo_clk)
	begin
		if (rst)
		begin
			count <= '0;
			length <= '0;
		end
		else if (request_length)
		begin
			length <= count;	// Held until next request
			count <= LEN_W'(count_en);	// Keep a byte from the same cycle
		end
		else if (count_en && (count != '1))
			count <= count + 1'b1;
	end

endmodule

// File: design/cmd_decoder.sv
//********************
// Host command decode, bit 7 set loads mask, clear loads prescale
// Reset enables all channels with no prescaling
//********************
`timescale 1ns/1ps

module cmd_decoder (
	input  logic                             fifo_clk,
	input  logic                             rst,
	input  logic [pulse_reg_pkg::BYTE_W-1:0] cmd,
	input  logic                             cmd_wr,
	output logic [6:0]                       chan_mask,
	output logic [6:0]                       prescale
);
	import pulse_reg_pkg::*;

	cmd_word_u cw;	// Same byte, two views

	assign cw = cmd;

	always_ff @(posedge fifo_clk)
	begin
		if (rst)
		begin
			chan_mask <= 7'h7f;
			prescale <= 7'd0;
		end
		else if (cmd_wr)
		begin
			if (cw.mask_v.tag)
				chan_mask <= cw.mask_v.mask;
			else
				prescale <= cw.presc_v.value;
		end
	end

endmodule

// File: design/fx2_bidir.sv
//********************
// FX2 slave FIFO master, FIFO2 down, FIFO6 up, FIFO8 length report
// All FX2 strobes and flags are active low, wakeup held high
// FIFO8 full flag is not checked, the length report is assumed to fit
//********************
`timescale 1ns/1ps

module fx2_bidir #(
	parameter int SHORT_PKT = 512	// Close FIFO6 packet below this count
) (
	input  logic                               fifo_clk,
	input  logic                               rst,
	inout  wire  [pulse_reg_pkg::BYTE_W-1:0]   fd,
	output logic                               slrd,
	output logic                               slwr,
	output logic                               sloe,
	output logic                               pktend,
	output logic [1:0]                         fifoadr,
	input  logic [2:0]                         flags,
	output logic                               wu2,
	input  logic [pulse_reg_pkg::BYTE_W-1:0]   word,
	input  logic                               word_avail,
	output logic                               word_accepted,
	output logic [pulse_reg_pkg::BYTE_W-1:0]   cmd,
	output logic                               cmd_wr,
	input  logic [pulse_reg_pkg::LEN_W-1:0]    length,
	output logic                               request_length
);
	import pulse_reg_pkg::*;

	localparam logic [LEN_W-1:0] SHORT_LEN = LEN_W'(SHORT_PKT);

	fx2_state_e state;

	logic fifo2_empty;
	logic fifo2_avail;
	logic fifo6_full;
	logic fifo_rd;	// Internal strobes, active high
	logic fifo_wr;
	logic fifo_pktend;
	logic datain_oe;
	logic tx_word;	// Event byte goes out this cycle
	logic [BYTE_W-1:0] length_byte;
	logic [BYTE_W-1:0] dataout;

	//********************
	// Flag decode
	//********************
	assign fifo2_empty = ~flags[0];
	assign fifo2_avail = ~fifo2_empty;
	assign fifo6_full = ~flags[1];
	assign wu2 = 1'b1;	// No remote wakeup

	//********************
	// FSM
	//********************
	always_ff @(posedge fifo_clk)
	begin
		if (rst)
			state <= st_idle;
		else
		begin
			case (state)
				st_listen:
					if (fifo2_avail)
						state <= st_turn_rx;	// Host commands first
					else if (fifo6_full)
						state <= st_idle;
				st_idle:
					if (fifo2_avail)
						state <= st_turn_rx;
					else if (!fifo6_full)
						state <= st_listen;	// Room again on FIFO6
				st_turn_rx:  state <= st_receive;
				st_receive:
					if (fifo2_empty)
						state <= st_wait_cnt;	// Burst done, report length
				st_wait_cnt: state <= st_len_hi;	// Tally latch settles
				st_len_hi:   state <= st_len_lo;
				st_len_lo:   state <= st_len_end;
				st_len_end:  state <= st_turn_tx;
				st_turn_tx:  state <= st_tx_end;
				st_tx_end:
					if (!fifo6_full)
						state <= st_listen;
					else
						state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

	assign fifoadr = state[3:2];	// FIFO select straight from the code

	// Downlink, one byte per cycle while FIFO2 has data
	assign fifo_rd = (state == st_receive) && fifo2_avail;
	assign cmd_wr = fifo_rd;
	assign cmd = fifo_rd ? fd : '0;
	assign datain_oe = (state[3:2] == 2'b00);	// Host drives bus on FIFO2
	assign request_length = (state == st_turn_rx);

	// Uplink
	assign tx_word = (state == st_listen) && word_avail && fifo2_empty && !fifo6_full;
	assign word_accepted = tx_word;

	// Shared output mux for event and length bytes
	assign length_byte = (state == st_len_hi) ? length[LEN_W-1:BYTE_W] : length[BYTE_W-1:0];
	assign dataout = (state == st_listen) ? word : length_byte;

	assign fifo_wr = tx_word || (state == st_len_hi) || (state == st_len_lo);
	assign fifo_pktend = (state == st_len_end)
		|| ((state == st_tx_end) && (length < SHORT_LEN));	// Short FIFO6 packet only

	//********************
	// Pin mapping
	//********************
	assign slrd = ~fifo_rd;
	assign slwr = ~fifo_wr;
	assign sloe = ~datain_oe;
	assign pktend = ~fifo_pktend;
	assign fd = fifo_wr ? dataout : 'z;	// Drive only on writes

endmodule

// File: design/pulse_reg_pkg.sv
//********************
// Shared types and widths for the pulse registration front end
// State codes carry the FX2 FIFO address in their upper two bits
//********************

package pulse_reg_pkg;

	localparam int BYTE_W = 8;	// Data byte on the FX2 bus
	localparam int LEN_W = 16;	// Length counter reported on FIFO8

	//********************
	// FX2 FSM states, bits [3:2] select the FIFO
	//********************
	typedef enum logic [3:0] {
		st_listen   = 4'b1011,	// FIFO6, send event bytes
		st_idle     = 4'b1001,	// FIFO6 full, wait
		st_turn_rx  = 4'b0001,	// FIFO2 bus turnaround
		st_receive  = 4'b0011,	// FIFO2 command read
		st_wait_cnt = 4'b1100,	// FIFO8, settle length
		st_len_hi   = 4'b1101,
		st_len_lo   = 4'b1110,
		st_len_end  = 4'b1111,	// FIFO8 pktend
		st_turn_tx  = 4'b1000,
		st_tx_end   = 4'b1010	// FIFO6 short packet close
	} fx2_state_e;

	// Command byte, tag bit picks the view
	typedef union packed {
		struct packed {
			logic       tag;	// 1
			logic [6:0] mask;	// Channel enables
		} mask_v;
		struct packed {
			logic       tag;	// 0
			logic [6:0] value;	// Emit every value+1 events
		} presc_v;
	} cmd_word_u;

endpackage

// File: design/pulse_reg_top.sv
//********************
// Pulse registration front end behind an FX2 slave FIFO port
// Single clock domain on the FX2 interface clock
//********************
`timescale 1ns/1ps

module pulse_reg_top #(
	parameter int CHANNELS    = 4,	// At most 7
	parameter int QUEUE_DEPTH = 16,	// Power of two
	parameter int SHORT_PKT   = 512
) (
	input  logic                             fifo_clk,
	input  logic                             rst,
	inout  wire  [pulse_reg_pkg::BYTE_W-1:0] fd,
	output logic                             slrd,
	output logic                             slwr,
	output logic                             sloe,
	output logic                             pktend,
	output logic [1:0]                       fifoadr,
	input  logic [2:0]                       flags,
	output logic                             wu2,
	input  logic [CHANNELS-1:0]              pulse_in
);
	import pulse_reg_pkg::*;

	logic [BYTE_W-1:0] ev_byte;	// Tagger to queue
	logic ev_strobe;
	logic [BYTE_W-1:0] word;	// Queue to FX2
	logic word_avail;
	logic word_accepted;
	logic [BYTE_W-1:0] cmd;	// FX2 to decoder
	logic cmd_wr;
	logic [6:0] chan_mask;
	logic [6:0] prescale;
	logic request_length;
	logic [LEN_W-1:0] length;

	pulse_tagger #(.CHANNELS(CHANNELS)) i_tagger (
		.fifo_clk(fifo_clk), .rst(rst), .pulse_in(pulse_in),
		.chan_mask(chan_mask), .prescale(prescale),
		.ev_byte(ev_byte), .ev_strobe(ev_strobe)
	);

	word_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.fifo_clk(fifo_clk), .rst(rst), .wr_byte(ev_byte), .wr(ev_strobe),
		.word(word), .word_avail(word_avail), .pop(word_accepted)
	);

	byte_tally i_tally (
		.fifo_clk(fifo_clk), .rst(rst), .count_en(word_accepted),
		.request_length(request_length), .length(length)
	);

	cmd_decoder i_decoder (
		.fifo_clk(fifo_clk), .rst(rst), .cmd(cmd), .cmd_wr(cmd_wr),
		.chan_mask(chan_mask), .prescale(prescale)
	);

	fx2_bidir #(.SHORT_PKT(SHORT_PKT)) i_fx2 (
		.fifo_clk(fifo_clk), .rst(rst), .fd(fd),
		.slrd(slrd), .slwr(slwr), .sloe(sloe), .pktend(pktend),
		.fifoadr(fifoadr), .flags(flags), .wu2(wu2),
		.word(word), .word_avail(word_avail), .word_accepted(word_accepted),
		.cmd(cmd), .cmd_wr(cmd_wr),
		.length(length), .request_length(request_length)
	);

endmodule

// File: design/pulse_tagger.sv
//********************
// Rising edge tagger, one event byte per accepted edge
// Lowest channel wins on coincident edges, the others are lost
// CHANNELS at most 7, id field is 3 bits
//********************
`timescale 1ns/1ps

module pulse_tagger #(
	parameter int CHANNELS = 4
) (
	input  logic                             fifo_clk,
	input  logic                             rst,
	input  logic [CHANNELS-1:0]              pulse_in,
	input  logic [6:0]                       chan_mask,
	input  logic [6:0]                       prescale,
	output logic [pulse_reg_pkg::BYTE_W-1:0] ev_byte,
	output logic                             ev_strobe
);
	logic [CHANNELS-1:0] pulse_q;	// Sample stage
	logic [CHANNELS-1:0] pulse_qq;	// Previous sample
	logic [CHANNELS-1:0] rise;
	logic [2:0] chan_id;
	logic hit;	// Any enabled edge this cycle
	logic [6:0] presc_cnt;
	logic [4:0] seq;

	//********************
	// Edge detect
	//********************
	always_ff @(posedge fifo_clk)
	begin
		if (rst)
		begin
			pulse_q <= '0;
			pulse_qq <= '0;
		end
		else
		begin
			pulse_q <= pulse_in;
			pulse_qq <= pulse_q;
		end
	end

	assign rise = pulse_q & ~pulse_qq & chan_mask[CHANNELS-1:0];	// Masked channels ignored

	// Priority pick, lowest index last so it wins
	always_comb
	begin
		hit = 1'b0;
		chan_id = 3'd0;
		for (int i = CHANNELS - 1; i >= 0; i--)
		begin
			if (rise[i])
			begin
				hit = 1'b1;
				chan_id = 3'(i);
			end
		end
	end

	//********************
	// Prescale and byte forming
	//********************
	always_ff @(posedge fifo_clk)
	begin
		if (rst)
		begin
			presc_cnt <= '0;
			seq <= '0;
			ev_strobe <= 1'b0;
		end
		else
		begin
			ev_strobe <= 1'b0;
			if (hit)
			begin
				if (presc_cnt >= prescale)	// Also catches a lowered prescale
				begin
					presc_cnt <= '0;
					seq <= seq + 1'b1;	// Wraps at 32
					ev_strobe <= 1'b1;
				end
				else
					presc_cnt <= presc_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge fifo_clk)
	begin
		if (hit)
			ev_byte <= {chan_id, seq};	// Id in [7:5], sequence in [4:0]
	end

endmodule

// File: design/word_queue.sv
//********************
// Byte FIFO, first word fall through
// QUEUE_DEPTH must be a power of two, writes while full are lost
//********************
`timescale 1ns/1ps

module word_queue #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                             fifo_clk,
	input  logic                             rst,
	input  logic [pulse_reg_pkg::BYTE_W-1:0] wr_byte,
	input  logic                             wr,
	output logic [pulse_reg_pkg::BYTE_W-1:0] word,
	output logic                             word_avail,
	input  logic                             pop
);
	import pulse_reg_pkg::*;

	localparam int ADDR_W = $clog2(QUEUE_DEPTH);

	logic [BYTE_W-1:0] mem [QUEUE_DEPTH];
	logic [ADDR_W:0] wr_ptr;	// Extra bit tells full from empty
	logic [ADDR_W:0] rd_ptr;
	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
		&& (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_wr = wr && !full;	// Drop on overflow
	assign do_rd = pop && !empty;

	// Storage
	always_ff @(posedge fifo_clk)
	begin
		if (do_wr)
			mem[wr_ptr[ADDR_W-1:0]] <= wr_byte;
	end

	//********************
	// Pointers
	//********************
	always_ff @(posedge fifo_clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign word = mem[rd_ptr[ADDR_W-1:0]];	// Head byte, valid with word_avail
	assign word_avail = !empty;

endmodule

// File: sim/tb_pulse_reg.sv
//********************
// Testbench for pulse_reg_top with an FX2 host FIFO model
// SHORT_PKT is lowered to 6 so that both FIFO6 pktend cases occur
//********************
`timescale 1ns/1ps

module tb_pulse_reg;
	import pulse_reg_pkg::*;

	localparam int CHANNELS = 4;
	localparam int QUEUE_DEPTH = 16;
	localparam int SHORT_PKT = 6;
	localparam int NROWS = 8;
	localparam int ROW_CYCLES = 300;	// Cycle budget per table row
	localparam logic [3:0] F6_CODE = st_listen;
	localparam logic [3:0] F8_CODE = st_len_hi;

	typedef struct {
		int ncmd;	// Command bytes in this row
		logic [7:0] cmd0;
		logic [7:0] cmd1;
		logic [3:0] on_set;	// Channels for even pulses
		logic [3:0] off_set;	// Channels for odd pulses, none if zero
		int npulse;
		bit hold;	// FIFO6 full while pulsing
		int exp_n;	// FIFO6 bytes this row
	} row_t;

	logic fifo_clk;
	logic rst;
	wire [BYTE_W-1:0] fd;
	logic slrd;
	logic slwr;
	logic sloe;
	logic pktend;
	logic wu2;
	logic [1:0] fifoadr;
	logic [2:0] flags;
	logic [CHANNELS-1:0] pulse_in;

	logic [BYTE_W-1:0] f2_mem [32];	// Host side FIFO2 contents
	int f2_wr = 0;
	int f2_rd = 0;
	bit f6_hold;
	logic [BYTE_W-1:0] f6_q [$];	// Captured uplink bytes
	logic [BYTE_W-1:0] f8_q [$];	// Captured length bytes
	int f6_pkt = 0;
	int f8_pkt = 0;
	int f6_pkt_exp;
	int n_rep;
	int since_report;
	int cycles = 0;
	int seed;
	logic [6:0] m_mask;	// Tagger model state
	logic [6:0] m_presc;
	logic [6:0] m_cnt;
	logic [4:0] m_seq;
	logic [BYTE_W-1:0] exp_q [$];
	row_t rows [NROWS];

	initial
	begin
		fifo_clk = 1'b0;
		forever
			#2 fifo_clk = ~fifo_clk;
	end

	pulse_reg_top #(.CHANNELS(CHANNELS), .QUEUE_DEPTH(QUEUE_DEPTH), .SHORT_PKT(SHORT_PKT)) i_dut (
		.fifo_clk(fifo_clk), .rst(rst), .fd(fd), .slrd(slrd), .slwr(slwr), .sloe(sloe),
		.pktend(pktend), .fifoadr(fifoadr), .flags(flags), .wu2(wu2), .pulse_in(pulse_in)
	);

	assign fd = !sloe ? f2_mem[f2_rd] : 'z;	// Host drives the head byte

	//********************
	// Host FIFO model
	//********************
	always @(posedge fifo_clk)
	begin
		if (!rst && !slrd)
			f2_rd <= f2_rd + 1;	// Pop after the DUT latched it
		if (!rst && !slwr && fifoadr == F6_CODE[3:2])
			f6_q.push_back(fd);
		if (!rst && !slwr && fifoadr == F8_CODE[3:2])
			f8_q.push_back(fd);
		if (!rst && !pktend && fifoadr == F6_CODE[3:2])
			f6_pkt++;
		if (!rst && !pktend && fifoadr == F8_CODE[3:2])
			f8_pkt++;
	end

	always @(posedge fifo_clk)
	begin
		if (!rst && !slwr && fifoadr == F6_CODE[3:2] && !flags[1])
		begin
			$display("FIFO6 was written while its full flag was set, at %0d ns", $time);
			$display("TESTS FAILED");
			$fatal(1, "write on full FIFO6");
		end
	end

	always @(posedge fifo_clk)
	begin
		cycles++;
		if (cycles > (NROWS + 1) * ROW_CYCLES)
		begin
			$display("Run exceeded its cycle limit, the DUT stopped responding");
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	//********************
	// Helpers
	//********************
	task automatic check_byte(input logic [BYTE_W-1:0] got, input logic [BYTE_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("Fail at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_length(input logic [LEN_W-1:0] got, input logic [LEN_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "length mismatch");
		end
	endtask

	// One cycle, flags follow the host state on the falling edge
	task automatic tick();
		@(negedge fifo_clk);
		flags = {1'b1, ~f6_hold, f2_rd != f2_wr};	// FIFO8 never full
	endtask

	function automatic int pick(input logic [3:0] set);
		int ch;
		ch = $unsigned($random(seed)) % CHANNELS;
		while (((set >> ch) & 4'd1) == 4'd0)
			ch = (ch + 1) % CHANNELS;
		return ch;
	endfunction

	// Tagger rule, one byte per prescale+1 accepted edges
	task automatic model_event(input int ch);
		if (((m_mask >> ch) & 7'd1) != 7'd0)
		begin
			if (m_cnt >= m_presc)
			begin
				exp_q.push_back({3'(ch), m_seq});
				m_seq++;	// Wraps at 32
				m_cnt = '0;
			end
			else
				m_cnt++;
		end
	endtask

	task automatic pulse(input int ch);
		pulse_in = CHANNELS'(1) << ch;
		repeat (2) tick();
		pulse_in = '0;
		repeat (3) tick();
	endtask

	task automatic send_cmds(input row_t r);
		cmd_word_u cw;
		int n8;
		int i;
		logic [LEN_W-1:0] exp_len;
		n8 = f8_pkt;
		exp_len = LEN_W'(since_report);
		for (i = 0; i < r.ncmd; i++)
		begin
			cw = (i == 0) ? r.cmd0 : r.cmd1;
			f2_mem[f2_wr] = cw;
			f2_wr++;
			if (cw.mask_v.tag)
				m_mask = cw.mask_v.mask;
			else
				m_presc = cw.presc_v.value;
		end
		while (f8_pkt == n8)
			tick();	// Until the FIFO8 pktend
		n_rep++;
		since_report = 0;
		check_length(LEN_W'(f8_q.size()), LEN_W'(2 * n_rep), "FIFO8 byte count");
		check_length({f8_q[2 * n_rep - 2], f8_q[2 * n_rep - 1]}, exp_len, "FIFO8 length");
		check_length(LEN_W'(f2_wr - f2_rd), '0, "FIFO2 bytes left");
		if (exp_len < SHORT_PKT)
			f6_pkt_exp++;	// Short packet close follows
	endtask

	task automatic run_row(input row_t r);
		int base;
		int ch;
		int i;
		base = exp_q.size();
		if (r.ncmd > 0)
			send_cmds(r);
		f6_hold = r.hold;
		repeat (2) tick();
		for (i = 0; i < r.npulse; i++)
		begin
			if ((i % 2 == 1) && (r.off_set != 0))
				ch = pick(r.off_set);
			else
				ch = pick(r.on_set);
			model_event(ch);
			pulse(ch);
		end
		if (r.hold)
		begin
			repeat (10) tick();
			check_length(LEN_W'(f6_q.size()), LEN_W'(base), "FIFO6 bytes while full");
			f6_hold = 1'b0;
		end
		while (f6_q.size() < exp_q.size())
			tick();
		repeat (10) tick();	// Stray bytes and late pktend
		check_length(LEN_W'(f6_q.size() - base), LEN_W'(r.exp_n), "FIFO6 bytes in row");
		check_length(LEN_W'(f6_q.size()), LEN_W'(exp_q.size()), "FIFO6 byte total");
		for (i = base; i < exp_q.size(); i++)
			check_byte(f6_q[i], exp_q[i], "FIFO6 event byte");
		check_length(LEN_W'(f6_pkt), LEN_W'(f6_pkt_exp), "FIFO6 pktend count");
		since_report += exp_q.size() - base;
	endtask

	//********************
	// Stimulus table and main sequence
	//********************
	initial
	begin
		// ncmd, cmd0, cmd1, on_set, off_set, npulse, hold, exp_n
		rows[0] = '{0, 8'h00, 8'h00, 4'hf, 4'h0, 6, 1'b0, 6};
		rows[1] = '{1, 8'h85, 8'h00, 4'h5, 4'ha, 8, 1'b0, 4};	// Mask ch0 and ch2
		rows[2] = '{2, 8'h02, 8'h8f, 4'hf, 4'h0, 9, 1'b0, 3};	// Prescale 2
		rows[3] = '{1, 8'h00, 8'h00, 4'hf, 4'h0, 5, 1'b0, 5};
		rows[4] = '{0, 8'h00, 8'h00, 4'hf, 4'h0, 12, 1'b1, 12};	// Back-pressure
		rows[5] = '{2, 8'h83, 8'h01, 4'h3, 4'hc, 10, 1'b0, 2};
		rows[6] = '{2, 8'h8f, 8'h00, 4'hf, 4'h0, 6, 1'b0, 6};	// Sequence wraps
		rows[7] = '{1, 8'h8f, 8'h00, 4'hf, 4'h0, 0, 1'b0, 0};	// Last report only
		seed = 31490;
		rst = 1'b1;
		flags = 3'b110;	// FIFO2 empty, room on FIFO6 and FIFO8
		pulse_in = '0;
		f6_hold = 1'b0;
		f6_pkt_exp = 0;
		n_rep = 0;
		since_report = 0;
		m_mask = 7'h7f;
		m_presc = '0;
		m_cnt = '0;
		m_seq = '0;
		repeat (4) @(negedge fifo_clk);
		rst = 1'b0;
		repeat (6) tick();
		check_byte(BYTE_W'({slrd, slwr, sloe, pktend, wu2}), 8'h1f, "idle pins");
		check_length(LEN_W'(f6_q.size() + f8_q.size()), '0, "writes before pulses");
		for (int k = 0; k < NROWS; k++)
			run_row(rows[k]);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: src.f
design/pulse_reg_pkg.sv
design/pulse_tagger.sv
design/word_queue.sv
design/byte_tally.sv
design/cmd_decoder.sv
design/fx2_bidir.sv
design/pulse_reg_top.sv
sim/tb_pulse_reg.sv
